/* rv32v_config.svh */
`ifndef RV32V_CONFIG_SVH
`define RV32V_CONFIG_SVH

// lanes in the execute datapath, one register bank per lane
`define RV32V_NUM_LANES 4

// architectural vector registers
`define RV32V_NUM_VREGS 32

// data memory depth in 32-bit words
`define RV32V_MEM_WORDS 256

// wishbone byte address width
`define RV32V_ADDR_W 32

`endif

/* rv32v_types_pkg.sv */
`include "rv32v_config.svh"

package rv32v_types_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0] vreg_idx_t;
    typedef logic [`RV32V_NUM_LANES-1:0] lane_mask_t;
    typedef logic [`RV32V_ADDR_W-1:0] wb_addr_t;

    // one element per lane, so a whole register
    typedef word_t [`RV32V_NUM_LANES-1:0] vlane_data_t;

    typedef enum logic [1:0] {
        VC_ALU,
        VC_LOAD,
        VC_STORE
    } vinstr_class_t;

    typedef enum logic [3:0] {
        VALU_ADD,
        VALU_SUB,
        VALU_AND,
        VALU_OR,
        VALU_XOR,
        VALU_MIN,
        VALU_MINU,
        VALU_MAX,
        VALU_MAXU,
        VALU_SEQ,
        VALU_SNE,
        VALU_SLT,
        VALU_SLTU,
        VALU_MV
    } valu_op_t;

    // where operand B comes from
    typedef enum logic [1:0] {
        SRC_VV,
        SRC_VX,
        SRC_VI
    } vsrc_t;

    typedef struct packed {
        vinstr_class_t vclass;
        valu_op_t      valuop;
        vsrc_t         vsrc;
        vreg_idx_t     vd;
        vreg_idx_t     vs1;
        vreg_idx_t     vs2;
        logic [4:0]    vimm;
        logic          vsignext;
        logic          vmask_en;
        word_t         rs1;
    } vissue_t;

    // vres doubles as store data for VC_STORE
    typedef struct packed {
        logic          valid;
        vinstr_class_t vclass;
        vreg_idx_t     vd;
        vlane_data_t   vres;
        lane_mask_t    vlane_mask;
        word_t         base;
    } vexmem_t;

    typedef struct packed {
        logic        wen;
        vreg_idx_t   vd;
        vlane_data_t vwdata;
        lane_mask_t  vlane_mask;
    } vwb_t;

    typedef struct packed {
        logic       cyc;
        logic       stb;
        logic       we;
        wb_addr_t   adr;
        word_t      dat_w;
        logic [3:0] sel;
    } wb_req_t;

    typedef struct packed {
        logic  ack;
        word_t dat_r;
    } wb_rsp_t;

    typedef enum logic [1:0] {
        MS_IDLE,
        MS_ACCESS,
        MS_WRITEBACK
    } mem_state_t;

endpackage

/* rv32v_vector_bank.sv */
`timescale 1ns/100ps
`include "rv32v_config.svh"

module rv32v_vector_bank
    import rv32v_types_pkg::*;
(
    input  logic      CLK,
    input  logic      rst_n,
    input  vreg_idx_t vs1,
    input  vreg_idx_t vs2,
    input  vreg_idx_t vs3,
    input  vreg_idx_t vw,
    input  word_t     vwdata,
    input  logic[3:0] byte_wen,
    output word_t     vdat1,
    output word_t     vdat2,
    output word_t     vdat3,
    output word_t     v0
);

    word_t regs [`RV32V_NUM_VREGS];
    word_t merged;
    logic  wr;

    assign wr = |byte_wen;

    // old word with the enabled bytes replaced
    always_comb begin
        merged = regs[vw];
        for (int b = 0; b < 4; b++) begin
            if (byte_wen[b]) begin
                merged[8*b +: 8] = vwdata[8*b +: 8];
            end
        end
    end

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `RV32V_NUM_VREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr) begin
            regs[vw] <= merged;
        end
    end

    // write-through so a dependent instruction sees the new value
    assign vdat1 = (wr && vs1 == vw) ? merged : regs[vs1];
    assign vdat2 = (wr && vs2 == vw) ? merged : regs[vs2];
    assign vdat3 = (wr && vs3 == vw) ? merged : regs[vs3];
    assign v0    = (wr && vw == '0) ? merged : regs[0];

endmodule

/* rv32v_vfu.sv */
`timescale 1ns/100ps

module rv32v_vfu
    import rv32v_types_pkg::*;
(
    input  word_t    vopA,
    input  word_t    vopB,
    input  logic     mask_bit,
    input  valu_op_t valuop,
    output word_t    vres
);

    word_t res;
    logic  lt_s;
    logic  lt_u;

    assign lt_s = $signed(vopA) < $signed(vopB);
    assign lt_u = vopA < vopB;

    // operand A is vs2, B is vs1 / rs1 / imm
    always_comb begin
        case (valuop)
            VALU_ADD:  res = vopA + vopB;
            VALU_SUB:  res = vopA - vopB;
            VALU_AND:  res = vopA & vopB;
            VALU_OR:   res = vopA | vopB;
            VALU_XOR:  res = vopA ^ vopB;
            VALU_MIN:  res = lt_s ? vopA : vopB;
            VALU_MINU: res = lt_u ? vopA : vopB;
            VALU_MAX:  res = lt_s ? vopB : vopA;
            VALU_MAXU: res = lt_u ? vopB : vopA;
            // compares write a whole 0/1 element, no mask packing
            VALU_SEQ:  res = word_t'(vopA == vopB);
            VALU_SNE:  res = word_t'(vopA != vopB);
            VALU_SLT:  res = word_t'(lt_s);
            VALU_SLTU: res = word_t'(lt_u);
            VALU_MV:   res = vopB;
            default:   res = '0;
        endcase
    end

    // inactive lane passes vs2 through
    assign vres = mask_bit ? res : vopA;

endmodule

/* rv32v_ex_datapath.sv */
`timescale 1ns/100ps
`include "rv32v_config.svh"

module rv32v_ex_datapath
    import rv32v_types_pkg::*;
(
    input  logic    CLK,
    input  logic    rst_n,
    input  logic    issue_valid,
    input  vissue_t issue,
    input  logic    busy,
    input  vwb_t    vwb,
    output logic    issue_ready,
    output vexmem_t vexmem
);

    vlane_data_t bankdat_src1;
    vlane_data_t bankdat_src2;
    vlane_data_t bankdat_src3;
    vlane_data_t v0_word;
    vlane_data_t vfu_res;
    word_t       ext_imm;
    lane_mask_t  lane_mask;
    logic        xfer;

    // memory stage owns the stall
    assign issue_ready = !busy;
    assign xfer = issue_valid && issue_ready;

    assign ext_imm = issue.vsignext ? {{27{issue.vimm[4]}}, issue.vimm}
                                    : {27'b0, issue.vimm};

    for (genvar k = 0; k < `RV32V_NUM_LANES; k++) begin : g_lane
        word_t opb;

        rv32v_vector_bank i_bank (
            .CLK      (CLK),
            .rst_n    (rst_n),
            .vs1      (issue.vs1),
            .vs2      (issue.vs2),
            .vs3      (issue.vd),
            .vw       (vwb.vd),
            .vwdata   (vwb.vwdata[k]),
            .byte_wen ({4{vwb.wen && vwb.vlane_mask[k]}}),
            .vdat1    (bankdat_src1[k]),
            .vdat2    (bankdat_src2[k]),
            .vdat3    (bankdat_src3[k]),
            .v0       (v0_word[k])
        );

        always_comb begin
            case (issue.vsrc)
                SRC_VX:  opb = issue.rs1;
                SRC_VI:  opb = ext_imm;
                default: opb = bankdat_src1[k];
            endcase
        end

        // element 0 of v0 lives in this lane's bank
        assign lane_mask[k] = issue.vmask_en ? v0_word[k][0] : 1'b1;

        rv32v_vfu i_vfu (
            .vopA     (bankdat_src2[k]),
            .vopB     (opb),
            .mask_bit (lane_mask[k]),
            .valuop   (issue.valuop),
            .vres     (vfu_res[k])
        );
    end

    always_comb begin
        vexmem.valid      = xfer;
        vexmem.vclass     = issue.vclass;
        vexmem.vd         = issue.vd;
        // stores carry vd's contents as data
        vexmem.vres       = (issue.vclass == VC_STORE) ? bankdat_src3 : vfu_res;
        vexmem.vlane_mask = lane_mask;
        vexmem.base       = issue.rs1;
    end

    // a load or store must stall the next issue
    a_mem_stalls: assert property (@(posedge CLK) disable iff (!rst_n)
        vexmem.valid && vexmem.vclass != VC_ALU |=> busy)
        else $error("memory instruction did not stall issue");

endmodule

/* rv32v_mem_stage.sv */
`timescale 1ns/100ps
`include "rv32v_config.svh"

module rv32v_mem_stage
    import rv32v_types_pkg::*;
(
    input  logic        CLK,
    input  logic        rst_n,
    input  vexmem_t     vexmem,
    input  wb_rsp_t     wb_rsp,
    output wb_req_t     wb_req,
    output vwb_t        vwb,
    output logic        busy,
    output logic        retire_valid,
    output vreg_idx_t   retire_vd,
    output vlane_data_t retire_data,
    output lane_mask_t  retire_mask
);

    localparam int LANE_W = $clog2(`RV32V_NUM_LANES);

    mem_state_t        state;
    vexmem_t           ex_q;
    lane_mask_t        pending;
    logic              gap;
    logic [LANE_W-1:0] lane;
    logic              acked;
    logic              done;
    logic              wb_wen;
    vreg_idx_t         wb_vd;
    vlane_data_t       wb_data;
    lane_mask_t        wb_mask;

    // lowest lane still waiting for its word
    always_comb begin
        lane = '0;
        for (int i = `RV32V_NUM_LANES - 1; i >= 0; i--) begin
            if (pending[i]) begin
                lane = LANE_W'(i);
            end
        end
    end

    always_comb begin
        wb_req.cyc   = (state == MS_ACCESS) && (pending != '0) && !gap;
        wb_req.stb   = wb_req.cyc;
        wb_req.we    = (ex_q.vclass == VC_STORE);
        wb_req.adr   = wb_addr_t'(ex_q.base + (word_t'(lane) << 2));
        wb_req.dat_w = ex_q.vres[lane];
        wb_req.sel   = 4'hf;
    end

    assign acked = wb_req.cyc && wb_rsp.ack;
    assign done  = (state == MS_ACCESS) && (pending == '0);
    assign busy  = (state != MS_IDLE);

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            state   <= MS_IDLE;
            pending <= '0;
            gap     <= 1'b0;
            wb_wen  <= 1'b0;
        end else begin
            // idle cycle after each word lets the host in
            gap    <= acked;
            wb_wen <= 1'b0;
            case (state)
                MS_IDLE: begin
                    if (vexmem.valid && vexmem.vclass == VC_ALU) begin
                        wb_wen <= 1'b1;
                    end else if (vexmem.valid) begin
                        state   <= MS_ACCESS;
                        pending <= vexmem.vlane_mask;
                    end
                end
                MS_ACCESS: begin
                    if (acked) begin
                        pending[lane] <= 1'b0;
                    end
                    if (done && ex_q.vclass == VC_LOAD) begin
                        state  <= MS_WRITEBACK;
                        wb_wen <= 1'b1;
                    end else if (done) begin
                        state <= MS_IDLE;
                    end
                end
                default: state <= MS_IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (vexmem.valid) begin
            ex_q <= vexmem;
        end else if (acked && ex_q.vclass == VC_LOAD) begin
            ex_q.vres[lane] <= wb_rsp.dat_r;
        end
        if (vexmem.valid) begin
            wb_vd   <= vexmem.vd;
            wb_data <= vexmem.vres;
            wb_mask <= vexmem.vlane_mask;
        end else if (done) begin
            // masked lanes are not written, so they keep their value
            wb_vd   <= ex_q.vd;
            wb_data <= ex_q.vres;
            wb_mask <= ex_q.vlane_mask;
        end
    end

    assign vwb.wen        = wb_wen;
    assign vwb.vd         = wb_vd;
    assign vwb.vwdata     = wb_data;
    assign vwb.vlane_mask = wb_mask;

    assign retire_valid = wb_wen;
    assign retire_vd    = wb_vd;
    assign retire_data  = wb_data;
    assign retire_mask  = wb_mask;

    // new work only arrives while the sequencer is idle
    a_accept_idle: assert property (@(posedge CLK) disable iff (!rst_n)
        vexmem.valid |-> state == MS_IDLE)
        else $error("instruction arrived while memory stage busy");

    // request is held through arbitration and memory latency
    a_req_hold: assert property (@(posedge CLK) disable iff (!rst_n)
        wb_req.stb && !wb_rsp.ack |=>
            wb_req.stb && $stable(wb_req.adr) && $stable(wb_req.we))
        else $error("wishbone request changed before ack");

endmodule

/* rv32v_wb_arbiter.sv */
`timescale 1ns/100ps

module rv32v_wb_arbiter
    import rv32v_types_pkg::*;
(
    input  logic    CLK,
    input  logic    rst_n,
    input  wb_req_t m0_req,
    input  wb_req_t m1_req,
    input  wb_rsp_t s_rsp,
    output wb_rsp_t m0_rsp,
    output wb_rsp_t m1_rsp,
    output wb_req_t s_req
);

    logic owner_vld;
    logic owner;
    logic last;
    logic pick;
    logic rearb;
    logic any_req;

    assign any_req = m0_req.cyc || m1_req.cyc;

    // grant is only released once the owner drops cyc
    assign rearb = !owner_vld || (owner ? !m1_req.cyc : !m0_req.cyc);

    // round robin on contention, else whoever asks
    assign pick = (m0_req.cyc && m1_req.cyc) ? !last : m1_req.cyc;

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            owner_vld <= 1'b0;
            owner     <= 1'b0;
            last      <= 1'b1;
        end else if (rearb) begin
            owner_vld <= any_req;
            owner     <= any_req ? pick : 1'b0;
            if (any_req) begin
                last <= pick;
            end
        end
    end

    always_comb begin
        s_req = '0;
        if (owner_vld) begin
            s_req = owner ? m1_req : m0_req;
        end
    end

    assign m0_rsp.dat_r = s_rsp.dat_r;
    assign m1_rsp.dat_r = s_rsp.dat_r;
    assign m0_rsp.ack   = s_rsp.ack && owner_vld && !owner;
    assign m1_rsp.ack   = s_rsp.ack && owner_vld && owner;

    // the ack returns to the master the memory served one cycle before
    a_ack_same_owner: assert property (@(posedge CLK) disable iff (!rst_n)
        s_rsp.ack |-> owner_vld && $stable(owner))
        else $error("slave ack routed to a different master");

    // slave ack must land on a master still in its cycle
    a_ack_in_cyc: assert property (@(posedge CLK) disable iff (!rst_n)
        (m0_rsp.ack |-> m0_req.cyc) and (m1_rsp.ack |-> m1_req.cyc))
        else $error("ack delivered outside a bus cycle");

endmodule

/* rv32v_data_mem.sv */
`timescale 1ns/100ps
`include "rv32v_config.svh"

module rv32v_data_mem
    import rv32v_types_pkg::*;
(
    input  logic    CLK,
    input  logic    rst_n,
    input  wb_req_t wb_req,
    output wb_rsp_t wb_rsp
);

    localparam int IDX_W = $clog2(`RV32V_MEM_WORDS);

    word_t            mem [`RV32V_MEM_WORDS];
    word_t            rdata;
    logic [IDX_W-1:0] idx;
    logic             access;
    logic             ack_q;

    assign idx = wb_req.adr[IDX_W+1:2];

    // one access per strobe, none in the ack cycle
    assign access = wb_req.cyc && wb_req.stb && !ack_q;

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    always_ff @(posedge CLK) begin
        if (access) begin
            rdata <= mem[idx];
            for (int b = 0; b < 4; b++) begin
                if (wb_req.we && wb_req.sel[b]) begin
                    mem[idx][8*b +: 8] <= wb_req.dat_w[8*b +: 8];
                end
            end
        end
    end

    assign wb_rsp.ack   = ack_q;
    assign wb_rsp.dat_r = rdata;

endmodule

/* rv32v_subsystem.sv */
`timescale 1ns/100ps

module rv32v_subsystem
    import rv32v_types_pkg::*;
(
    input  logic        CLK,
    input  logic        rst_n,
    input  logic        issue_valid,
    input  vissue_t     issue,
    output logic        issue_ready,
    input  wb_req_t     host_req,
    output wb_rsp_t     host_rsp,
    output logic        retire_valid,
    output vreg_idx_t   retire_vd,
    output vlane_data_t retire_data,
    output lane_mask_t  retire_mask
);

    vexmem_t vexmem;
    vwb_t    vwb;
    logic    busy;
    wb_req_t ms_req;
    wb_rsp_t ms_rsp;
    wb_req_t s_req;
    wb_rsp_t s_rsp;

    rv32v_ex_datapath i_ex_datapath (
        .CLK         (CLK),
        .rst_n       (rst_n),
        .issue_valid (issue_valid),
        .issue       (issue),
        .busy        (busy),
        .vwb         (vwb),
        .issue_ready (issue_ready),
        .vexmem      (vexmem)
    );

    rv32v_mem_stage i_mem_stage (
        .CLK          (CLK),
        .rst_n        (rst_n),
        .vexmem       (vexmem),
        .wb_rsp       (ms_rsp),
        .wb_req       (ms_req),
        .vwb          (vwb),
        .busy         (busy),
        .retire_valid (retire_valid),
        .retire_vd    (retire_vd),
        .retire_data  (retire_data),
        .retire_mask  (retire_mask)
    );

    // vector unit is master 0, host is master 1
    rv32v_wb_arbiter i_wb_arbiter (
        .CLK    (CLK),
        .rst_n  (rst_n),
        .m0_req (ms_req),
        .m1_req (host_req),
        .s_rsp  (s_rsp),
        .m0_rsp (ms_rsp),
        .m1_rsp (host_rsp),
        .s_req  (s_req)
    );

    rv32v_data_mem i_data_mem (
        .CLK    (CLK),
        .rst_n  (rst_n),
        .wb_req (s_req),
        .wb_rsp (s_rsp)
    );

endmodule

/* tb_rv32v_subsystem.sv */
`timescale 1ns/100ps

module tb_rv32v_subsystem
    import rv32v_types_pkg::*;
();

    localparam int N_INSTR = 600;
    // instruction budget plus the memory preload by the host
    localparam int LIMIT_CYCLES = N_INSTR * 64 + 256 * 8;

    typedef struct packed {
        vreg_idx_t   vd;
        vlane_data_t data;
        lane_mask_t  mask;
    } exp_t;

    logic        CLK;
    logic        rst_n;
    logic        issue_valid;
    vissue_t     issue;
    logic        issue_ready;
    wb_req_t     host_req;
    wb_rsp_t     host_rsp;
    logic        retire_valid;
    vreg_idx_t   retire_vd;
    vlane_data_t retire_data;
    lane_mask_t  retire_mask;

    vlane_data_t regs_m [32];
    word_t       mem_m [256];
    exp_t        exp_q [$];
    int          errors;
    logic        retire_ok;
    logic        stop_host;

    rv32v_subsystem i_rv32v_subsystem (
        .CLK          (CLK),
        .rst_n        (rst_n),
        .issue_valid  (issue_valid),
        .issue        (issue),
        .issue_ready  (issue_ready),
        .host_req     (host_req),
        .host_rsp     (host_rsp),
        .retire_valid (retire_valid),
        .retire_vd    (retire_vd),
        .retire_data  (retire_data),
        .retire_mask  (retire_mask)
    );

    always #4 CLK = ~CLK;

    // per-lane rule, operand a is vs2
    function automatic word_t alu_ref(valu_op_t op, word_t a, word_t b);
        case (op)
            VALU_ADD:  return a + b;
            VALU_SUB:  return a - b;
            VALU_AND:  return a & b;
            VALU_OR:   return a | b;
            VALU_XOR:  return a ^ b;
            VALU_MIN:  return ($signed(a) < $signed(b)) ? a : b;
            VALU_MINU: return (a < b) ? a : b;
            VALU_MAX:  return ($signed(a) > $signed(b)) ? a : b;
            VALU_MAXU: return (a > b) ? a : b;
            VALU_SEQ:  return (a == b) ? 32'd1 : 32'd0;
            VALU_SNE:  return (a != b) ? 32'd1 : 32'd0;
            VALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            VALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            default:   return b;
        endcase
    endfunction

    // reference model, applied in program order at each transfer
    task automatic model(input vissue_t ins);
        vlane_data_t res;
        lane_mask_t  m;
        word_t       b;
        int          base;
        base = int'(ins.rs1[9:2]);
        for (int k = 0; k < 4; k++) begin
            m[k] = ins.vmask_en ? regs_m[0][k][0] : 1'b1;
        end
        for (int k = 0; k < 4; k++) begin
            case (ins.vsrc)
                SRC_VX:  b = ins.rs1;
                SRC_VI:  b = ins.vsignext ? word_t'($signed(ins.vimm)) : word_t'(ins.vimm);
                default: b = regs_m[ins.vs1][k];
            endcase
            if (ins.vclass == VC_ALU) begin
                res[k] = alu_ref(ins.valuop, regs_m[ins.vs2][k], b);
            end else begin
                res[k] = mem_m[(base + k) % 256];
            end
        end
        if (ins.vclass == VC_STORE) begin
            for (int k = 0; k < 4; k++) begin
                if (m[k]) mem_m[(base + k) % 256] = regs_m[ins.vd][k];
            end
        end else begin
            exp_q.push_back('{vd: ins.vd, data: res, mask: m});
            for (int k = 0; k < 4; k++) begin
                if (m[k]) regs_m[ins.vd][k] = res[k];
            end
        end
    endtask

    // call right after a rising edge; holds the instruction until taken
    task automatic send(input vissue_t ins);
        issue_valid <= 1'b1;
        issue <= ins;
        do @(posedge CLK); while (!issue_ready);
        model(ins);
    endtask

    task automatic wait_idle();
        issue_valid <= 1'b0;
        do @(posedge CLK); while (!issue_ready);
    endtask

    function automatic vissue_t rand_alu(logic men);
        vissue_t ins;
        ins.vclass   = VC_ALU;
        ins.valuop   = valu_op_t'($urandom_range(13));
        ins.vsrc     = vsrc_t'($urandom_range(2));
        ins.vd       = vreg_idx_t'($urandom_range(31, 1));
        ins.vs1      = vreg_idx_t'($urandom_range(31));
        ins.vs2      = vreg_idx_t'($urandom_range(31));
        ins.vimm     = 5'($urandom);
        ins.vsignext = 1'($urandom);
        ins.vmask_en = men;
        ins.rs1      = $urandom;
        return ins;
    endfunction

    function automatic vissue_t mem_instr(vinstr_class_t c, int vd, int widx, logic men);
        vissue_t ins;
        ins          = '0;
        ins.vclass   = c;
        ins.vd       = vreg_idx_t'(vd);
        ins.vmask_en = men;
        ins.rs1      = word_t'(widx * 4);
        return ins;
    endfunction

    // one host access; reads are compared against the memory mirror
    task automatic host_xfer(input logic we, input int idx, input word_t wd);
        word_t rd;
        host_req.cyc   <= 1'b1;
        host_req.stb   <= 1'b1;
        host_req.we    <= we;
        host_req.adr   <= wb_addr_t'(idx * 4);
        host_req.dat_w <= wd;
        host_req.sel   <= 4'hf;
        do @(posedge CLK); while (!host_rsp.ack);
        rd = host_rsp.dat_r;
        host_req.cyc <= 1'b0;
        host_req.stb <= 1'b0;
        if (we) begin
            mem_m[idx] = wd;
        end else begin
            assert (rd === mem_m[idx]) else begin
                $display("[ERROR] %0t host read word %0d got %h expected %h",
                         $time, idx, rd, mem_m[idx]);
                errors++;
            end
        end
        // cyc must fall so the arbiter can re-arbitrate
        @(posedge CLK);
    endtask

    always @(negedge CLK) begin
        logic ok;
        ok = 1'b1;
        if (retire_valid) begin
            if (exp_q.size() == 0) begin
                ok = 1'b0;
            end else if (retire_vd != exp_q[0].vd || retire_mask != exp_q[0].mask) begin
                ok = 1'b0;
            end else begin
                for (int k = 0; k < 4; k++) begin
                    if (exp_q[0].mask[k] && retire_data[k] !== exp_q[0].data[k]) ok = 1'b0;
                end
            end
        end
        retire_ok <= ok;
    end

    always @(posedge CLK) begin
        if (retire_valid && exp_q.size() > 0) begin
            void'(exp_q.pop_front());
        end
    end

    a_retire_value: assert property (@(posedge CLK) disable iff (!rst_n) retire_ok)
        else begin
            $display("[ERROR] %0t retire vd=%0d data=%h mask=%b does not match model",
                     $time, retire_vd, retire_data, retire_mask);
            errors++;
        end

    a_alu_latency: assert property (@(posedge CLK) disable iff (!rst_n)
        (issue_valid && issue_ready && issue.vclass == VC_ALU) |=> retire_valid)
        else begin
            $display("[ERROR] %0t ALU retire not one cycle after transfer", $time);
            errors++;
        end

    initial begin
        repeat (LIMIT_CYCLES) @(posedge CLK);
        $display("timeout: run did not complete within %0d cycles", LIMIT_CYCLES);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        int      widx;
        vissue_t masked_op;
        void'($urandom(32'hdafd_fd39));
        CLK = 1'b0;
        rst_n = 1'b0;
        issue_valid = 1'b0;
        issue = '0;
        host_req = '0;
        errors = 0;
        stop_host = 1'b0;
        retire_ok = 1'b1;
        for (int r = 0; r < 32; r++) regs_m[r] = '0;
        repeat (8) @(posedge CLK);
        rst_n <= 1'b1;
        @(posedge CLK);
        assert (issue_ready && !retire_valid && !host_rsp.ack) else begin
            $display("[ERROR] %0t outputs not idle after reset", $time);
            errors++;
        end

        // every register reads zero after reset
        for (int r = 0; r < 32; r++) begin
            send('{vclass: VC_ALU, valuop: VALU_OR, vsrc: SRC_VV, vd: 5'(31 - r),
                   vs1: 5'(r), vs2: 5'(31 - r), vimm: 5'd0, vsignext: 1'b0,
                   vmask_en: 1'b0, rs1: 32'd0});
        end
        wait_idle();

        for (int i = 0; i < 256; i++) host_xfer(1'b1, i, $urandom);

        for (int i = 0; i < 200; i++) send(rand_alu(1'b0));
        wait_idle();

        // masked ops under a v0 loaded from memory
        for (int i = 0; i < 10; i++) begin
            widx = $urandom_range(124);
            send(mem_instr(VC_LOAD, 0, widx, 1'b0));
            masked_op = rand_alu(1'b1);
            send(masked_op);
            send('{vclass: VC_ALU, valuop: VALU_MV, vsrc: SRC_VV, vd: 5'd30,
                   vs1: masked_op.vd, vs2: 5'd0,
                   vimm: 5'd0, vsignext: 1'b0, vmask_en: 1'b0, rs1: 32'd0});
            send('{vclass: VC_ALU, valuop: VALU_ADD, vsrc: SRC_VX, vd: 5'd5,
                   vs1: 5'd0, vs2: 5'd7, vimm: 5'd0, vsignext: 1'b0,
                   vmask_en: 1'b0, rs1: $urandom});
            send('{vclass: VC_ALU, valuop: VALU_XOR, vsrc: SRC_VV, vd: 5'd6,
                   vs1: 5'd5, vs2: 5'd7, vimm: 5'd0, vsignext: 1'b0,
                   vmask_en: 1'b0, rs1: 32'd0});
            wait_idle();
        end

        // stores, then host readback of the touched window
        for (int i = 0; i < 20; i++) begin
            widx = $urandom_range(124);
            send(mem_instr(VC_STORE, $urandom_range(31, 1), widx, 1'($urandom)));
            wait_idle();
            for (int k = 0; k < 4; k++) host_xfer(1'b0, widx + k, 32'd0);
        end

        // mixed traffic with the host active in its own upper half
        fork
            begin
                while (!stop_host) begin
                    if ($urandom_range(1)) begin
                        host_xfer(1'($urandom), $urandom_range(255, 128), $urandom);
                    end else begin
                        @(posedge CLK);
                    end
                end
            end
            begin
                for (int i = 0; i < 150; i++) begin
                    widx = $urandom_range(124);
                    case ($urandom_range(2))
                        0: send(mem_instr(VC_LOAD, $urandom_range(31, 1), widx,
                                          1'($urandom)));
                        1: send(mem_instr(VC_STORE, $urandom_range(31, 1), widx,
                                          1'($urandom)));
                        default: send(rand_alu(1'($urandom)));
                    endcase
                end
                wait_idle();
                stop_host = 1'b1;
            end
        join
        repeat (4) @(posedge CLK);
        if (exp_q.size() != 0) begin
            $display("%0d expected retires never arrived", exp_q.size());
            errors++;
        end
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* rv32v_subsystem.f */
+incdir+.
rv32v_types_pkg.sv
rv32v_vector_bank.sv
rv32v_vfu.sv
rv32v_ex_datapath.sv
rv32v_mem_stage.sv
rv32v_wb_arbiter.sv
rv32v_data_mem.sv
rv32v_subsystem.sv
tb_rv32v_subsystem.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_rv32v_subsystem
FILELIST  := rv32v_subsystem.f

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard *.svh)
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee /dev/stderr | grep -q "Finished with no errors"

clean:
	rm -rf obj_dir
